// ==== source/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

    // word format, Q6.10 unless the top level picks another FRAC_W
    localparam int DATA_W     = 16;
    localparam int DEF_FRAC_W = 10;

    // room for acc << FRAC_W plus a full product, with a spare sign bit
    localparam int WIDE_W = 2 * DATA_W + 2;

    // upper bound on LFSR steps in one operation
    localparam int LFSR_MAX_STEPS = 8;

    typedef logic signed [DATA_W-1:0] data_t;
    typedef logic signed [WIDE_W-1:0] wide_t;

    // codes 4, 8 and up have no unit and read as zero
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_MUL  = 4'd2,
        OP_MAC  = 4'd3,
        OP_CLZ  = 4'd5,
        OP_LRCW = 4'd6,
        OP_LFSR = 4'd7
    } opcode_t;

    localparam data_t DATA_MAX = {1'b0, {(DATA_W-1){1'b1}}};
    localparam data_t DATA_MIN = {1'b1, {(DATA_W-1){1'b0}}};

    // clamp a wide signed value into one word
    function automatic data_t sat_word(input wide_t value);
        if (value > wide_t'(DATA_MAX)) begin
            return DATA_MAX;
        end else if (value < wide_t'(DATA_MIN)) begin
            return DATA_MIN;
        end else begin
            return data_t'(value[DATA_W-1:0]);
        end
    endfunction

endpackage

`default_nettype wire

// ==== source/alu_operand_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface alu_operand_if import alu_pkg::*; ();

    data_t   data_a;
    data_t   data_b;
    opcode_t opcode;
    // last registered result, feeds MAC
    data_t   acc;

    // execution units only read
    modport unit (
        input data_a,
        input data_b,
        input opcode,
        input acc
    );

    // result stage closes the accumulator loop
    modport store (
        output acc,
        input  opcode
    );

endinterface

`default_nettype wire

// ==== source/alu_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_sequencer (
    input  logic i_clk,
    input  logic i_rst_n,
    output logic o_busy,
    output logic o_valid,
    output logic o_load
);

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_COMPUTE = 2'd1,
        ST_OUTPUT  = 2'd2
    } state_t;

    state_t state;
    state_t state_nxt;

    // free-running three-phase frame, never stalls
    always_comb begin
        case (state)
            ST_IDLE:    state_nxt = ST_COMPUTE;
            ST_COMPUTE: state_nxt = ST_OUTPUT;
            default:    state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= ST_IDLE;
            o_busy  <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            state   <= state_nxt;
            // status reflects the state just left
            o_busy  <= (state != ST_OUTPUT);
            o_valid <= (state == ST_OUTPUT);
        end
    end

    // result register loads on the edge that raises o_valid
    assign o_load = (state == ST_OUTPUT);

endmodule

`default_nettype wire

// ==== source/alu_fixed_arith.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_fixed_arith import alu_pkg::*; #(
    parameter int FRAC_W = DEF_FRAC_W
) (
    alu_operand_if.unit bus,
    output data_t       o_sum,
    output data_t       o_diff,
    output data_t       o_prod,
    output data_t       o_mac
);

    wide_t a_ext;
    wide_t b_ext;
    wide_t acc_ext;
    wide_t sum_full;
    wide_t diff_full;
    wide_t prod_full;
    wide_t mac_full;

    // sign extend everything into the wide domain
    assign a_ext   = wide_t'(bus.data_a);
    assign b_ext   = wide_t'(bus.data_b);
    assign acc_ext = wide_t'(bus.acc);

    // exact, no overflow possible at this width
    assign sum_full  = a_ext + b_ext;
    assign diff_full = a_ext - b_ext;

    // product carries 2*FRAC_W fraction bits
    assign prod_full = a_ext * b_ext;

    // accumulator lined up with the product's binary point
    assign mac_full = (acc_ext <<< FRAC_W) + prod_full;

    assign o_sum  = sat_word(sum_full);
    assign o_diff = sat_word(diff_full);

    // arithmetic shift back to FRAC_W fraction bits, rounds toward minus infinity
    assign o_prod = sat_word(prod_full >>> FRAC_W);
    assign o_mac  = sat_word(mac_full >>> FRAC_W);

endmodule

`default_nettype wire

// ==== source/alu_bit_ops.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_bit_ops import alu_pkg::*; (
    alu_operand_if.unit bus,
    output data_t       o_clz,
    output data_t       o_lrcw,
    output data_t       o_lfsr
);

    localparam int NIB_N = DATA_W / 4;
    localparam int CNT_W = $clog2(DATA_W + 1);

    // feedback taps at bits 15, 13, 12 and 10
    localparam logic [DATA_W-1:0] TAP_MASK = 16'hB400;

    // 4-bit priority encoder: {any bit set, index of highest set bit}
    function automatic logic [2:0] pri4(input logic [3:0] d);
        logic [1:0] idx;
        idx[1] = d[3] | d[2];
        idx[0] = d[3] | (~d[2] & d[1]);
        return {|d, idx};
    endfunction

    logic [NIB_N-1:0]    nib_vld;
    logic [1:0]          nib_idx [NIB_N];
    logic [2:0]          grp_enc;
    logic [3:0]          msb_idx;
    logic [CNT_W-1:0]    clz_cnt;
    logic [CNT_W-1:0]    pop_cnt;
    logic [2*DATA_W-1:0] lrcw_pair;
    logic [3:0]          lfsr_steps;
    logic [DATA_W-1:0]   lfsr_state;

    // leading zeros, nibble encoders then one encoder over the nibble flags
    always_comb begin
        for (int g = 0; g < NIB_N; g++) begin
            {nib_vld[g], nib_idx[g]} = pri4(bus.data_a[4*g +: 4]);
        end
        grp_enc = pri4(nib_vld);
        msb_idx = {grp_enc[1:0], nib_idx[grp_enc[1:0]]};
        if (grp_enc[2]) begin
            clz_cnt = CNT_W'(DATA_W - 1) - {1'b0, msb_idx};
        end else begin
            // all zero
            clz_cnt = CNT_W'(DATA_W);
        end
    end

    // popcount of a, 0 to 16
    always_comb begin
        pop_cnt = '0;
        for (int i = 0; i < DATA_W; i++) begin
            pop_cnt = pop_cnt + CNT_W'(bus.data_a[i]);
        end
    end

    // b stacked on its own complement; shifting the pair by n leaves b << n
    // in the top half with the n bits shifted out, inverted, behind it
    assign lrcw_pair = {bus.data_b, ~bus.data_b} << pop_cnt;

    // step count from b[3:0], capped
    assign lfsr_steps = (bus.data_b[3:0] > 4'(LFSR_MAX_STEPS)) ?
                        4'(LFSR_MAX_STEPS) : bus.data_b[3:0];

    // unrolled steps, later ones bypassed past the requested count
    always_comb begin
        lfsr_state = bus.data_a;
        for (int s = 0; s < LFSR_MAX_STEPS; s++) begin
            if (4'(s) < lfsr_steps) begin
                lfsr_state = {lfsr_state[DATA_W-2:0], ^(lfsr_state & TAP_MASK)};
            end
        end
    end

    assign o_clz  = data_t'({{(DATA_W-CNT_W){1'b0}}, clz_cnt});
    assign o_lrcw = data_t'(lrcw_pair[2*DATA_W-1 -: DATA_W]);
    assign o_lfsr = data_t'(lfsr_state);

endmodule

`default_nettype wire

// ==== source/alu_result_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_result_stage import alu_pkg::*; (
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_load,
    alu_operand_if.store bus,
    input  data_t        i_sum,
    input  data_t        i_diff,
    input  data_t        i_prod,
    input  data_t        i_mac,
    input  data_t        i_clz,
    input  data_t        i_lrcw,
    input  data_t        i_lfsr,
    output data_t        o_result
);

    data_t unit_result;

    // dropped and unused opcodes give zero
    always_comb begin
        case (bus.opcode)
            OP_ADD:  unit_result = i_sum;
            OP_SUB:  unit_result = i_diff;
            OP_MUL:  unit_result = i_prod;
            OP_MAC:  unit_result = i_mac;
            OP_CLZ:  unit_result = i_clz;
            OP_LRCW: unit_result = i_lrcw;
            OP_LFSR: unit_result = i_lfsr;
            default: unit_result = '0;
        endcase
    end

    // one load per frame, so MAC accumulates once per result
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_result <= '0;
        end else if (i_load) begin
            o_result <= unit_result;
        end
    end

    // held result goes back as the accumulator
    assign bus.acc = o_result;

endmodule

`default_nettype wire

// ==== source/alu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_top import alu_pkg::*; #(
    parameter int FRAC_W = DEF_FRAC_W
) (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  data_t      i_data_a,
    input  data_t      i_data_b,
    input  logic [3:0] i_inst,
    output logic       o_valid,
    output logic       o_busy,
    output data_t      o_data
);

    logic  load;
    data_t sum;
    data_t diff;
    data_t prod;
    data_t mac;
    data_t clz;
    data_t lrcw;
    data_t lfsr;

    alu_operand_if u_bus ();

    // port operands onto the shared bundle
    assign u_bus.data_a = i_data_a;
    assign u_bus.data_b = i_data_b;
    assign u_bus.opcode = opcode_t'(i_inst);

    alu_sequencer u_sequencer (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .o_busy  (o_busy),
        .o_valid (o_valid),
        .o_load  (load)
    );

    alu_fixed_arith #(
        .FRAC_W (FRAC_W)
    ) u_fixed_arith (
        .bus    (u_bus),
        .o_sum  (sum),
        .o_diff (diff),
        .o_prod (prod),
        .o_mac  (mac)
    );

    alu_bit_ops u_bit_ops (
        .bus    (u_bus),
        .o_clz  (clz),
        .o_lrcw (lrcw),
        .o_lfsr (lfsr)
    );

    alu_result_stage u_result_stage (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_load   (load),
        .bus      (u_bus),
        .i_sum    (sum),
        .i_diff   (diff),
        .i_prod   (prod),
        .i_mac    (mac),
        .i_clz    (clz),
        .i_lrcw   (lrcw),
        .i_lfsr   (lfsr),
        .o_result (o_data)
    );

endmodule

`default_nettype wire

// ==== tb/alu_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_chk import alu_pkg::*; (
    input logic  i_clk,
    input logic  i_rst_n,
    input logic  i_valid,
    input logic  i_busy,
    input data_t i_data
);

    // valid and busy are complementary in the frame
    a_valid_not_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_valid && i_busy))
        else $error("o_valid and o_busy high together");

    // one valid cycle in three
    a_valid_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_valid |=> !i_valid ##1 !i_valid)
        else $error("o_valid high again within two cycles");

    // result register only moves when valid rises
    a_data_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !$rose(i_valid) |-> $stable(i_data))
        else $error("o_data changed outside a valid rise");

endmodule

bind alu_top alu_chk u_chk (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_valid (o_valid),
    .i_busy  (o_busy),
    .i_data  (o_data)
);

`default_nettype wire

// ==== tb/alu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_tb import alu_pkg::*; ();

    localparam int RST_CYCLES    = 16;
    localparam int VALID_TIMEOUT = 10;
    localparam     VEC_FILE      = "tb/alu_testdata.hex";

    // cycles from one valid to the next
    localparam int FRAME_LEN       = 3;
    // first wait also covers the edge that leaves reset
    localparam int FIRST_FRAME_LEN = 4;

    logic       clk;
    logic       rst_n;
    data_t      data_a;
    data_t      data_b;
    logic [3:0] inst;
    logic       valid;
    logic       busy;
    data_t      data_out;

    // vector table, one entry per data line
    logic [3:0] vec_op   [$];
    data_t      vec_a    [$];
    data_t      vec_b    [$];
    data_t      vec_exp  [$];
    int         vec_line [$];

    int mismatch_cnt;
    int other_cnt;

    alu_top i_alu_top (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_data_a (data_a),
        .i_data_b (data_b),
        .i_inst   (inst),
        .o_valid  (valid),
        .o_busy   (busy),
        .o_data   (data_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic string op_name(input logic [3:0] op);
        case (op)
            OP_ADD:  return "ADD";
            OP_SUB:  return "SUB";
            OP_MUL:  return "MUL";
            OP_MAC:  return "MAC";
            OP_CLZ:  return "CLZ";
            OP_LRCW: return "LRCW";
            OP_LFSR: return "LFSR";
            default: return $sformatf("OP%0d", op);
        endcase
    endfunction

    // comment lines start with //, data lines hold four hex fields
    task automatic load_vectors();
        int          fd;
        int          line_no;
        int          fields;
        string       line;
        logic [3:0]  op;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] exp_val;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("ERROR: cannot open vector file %s", VEC_FILE);
            other_cnt++;
            return;
        end
        line_no = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line.substr(0, 1) == "//") begin
                continue;
            end
            fields = $sscanf(line, "%h %h %h %h", op, a, b, exp_val);
            if (fields == 4) begin
                vec_op.push_back(op);
                vec_a.push_back(data_t'(a));
                vec_b.push_back(data_t'(b));
                vec_exp.push_back(data_t'(exp_val));
                vec_line.push_back(line_no);
            end else begin
                $display("ERROR: malformed vector on line %0d", line_no);
                other_cnt++;
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_vector(input int idx);
        inst   <= vec_op[idx];
        data_a <= vec_a[idx];
        data_b <= vec_b[idx];
    endtask

    // outputs are read at the edge, before the DUT updates them
    task automatic wait_for_valid(input string name, input int frame_len, input data_t held,
                                  output bit seen, output int cycles);
        bit exp_busy;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < VALID_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            // busy in the two cycles before each valid, low out of reset
            exp_busy = (cycles > frame_len - FRAME_LEN) && (cycles < frame_len);
            if (busy !== exp_busy) begin
                $display("MISMATCH %s o_busy at cycle %0d expected %b actual %b",
                         name, cycles, exp_busy, busy);
                mismatch_cnt++;
            end
            if (valid) begin
                seen = 1'b1;
            end else if (data_out !== held) begin
                $display("MISMATCH %s held o_data expected %h actual %h",
                         name, held, data_out);
                mismatch_cnt++;
            end
        end
    endtask

    initial begin
        bit    got_valid;
        string test_name;
        int    frame_len;
        int    wait_cycles;
        data_t held_exp;
        mismatch_cnt = 0;
        other_cnt    = 0;
        rst_n        = 1'b0;
        data_a       = '0;
        data_b       = '0;
        inst         = '0;

        load_vectors();
        if (vec_op.size() == 0) begin
            $display("ERROR: no test vectors were read");
            other_cnt++;
        end

        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        if (vec_op.size() > 0) begin
            apply_vector(0);
        end

        for (int i = 0; i < vec_op.size(); i++) begin
            test_name = $sformatf("%s@%0d", op_name(vec_op[i]), vec_line[i]);
            // o_data holds the reset value, then the previous result
            held_exp  = (i == 0) ? data_t'(0) : vec_exp[i-1];
            frame_len = (i == 0) ? FIRST_FRAME_LEN : FRAME_LEN;
            wait_for_valid(test_name, frame_len, held_exp, got_valid, wait_cycles);
            if (!got_valid) begin
                $display("ERROR: o_valid never came within %0d cycles for %s",
                         VALID_TIMEOUT, test_name);
                other_cnt++;
                break;
            end
            if (wait_cycles != frame_len) begin
                $display("MISMATCH %s frame cycles expected %0d actual %0d",
                         test_name, frame_len, wait_cycles);
                mismatch_cnt++;
            end
            if (data_out !== vec_exp[i]) begin
                $display("MISMATCH %s expected %h actual %h",
                         test_name, vec_exp[i], data_out);
                mismatch_cnt++;
            end
            // next operands go in at the same edge
            if (i + 1 < vec_op.size()) begin
                apply_vector(i + 1);
            end
        end

        $display("vectors: %0d, mismatches: %0d, other errors: %0d",
                 vec_op.size(), mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/alu_testdata.hex ====
// opcode a b expected, all hex, operands in Q6.10
// MAC lines add a*b to the previous line's result
3 0200 0400 0200
0 0400 0200 0600
0 7000 2000 7FFF
0 9000 A000 8000
0 FC00 0100 FD00
1 0400 0600 FE00
1 7000 9000 7FFF
1 8000 0001 8000
1 8000 8000 0000
2 0600 0200 0300
2 0800 FA00 F400
2 FFFF 0001 FFFF
2 0155 FD00 FF00
2 0003 0100 0000
2 4000 4000 7FFF
2 4000 C000 8000
4 1234 5678 0000
8 3C00 0400 0000
F FFFF FFFF 0000
3 0400 0400 0400
3 0600 0200 0700
3 FC00 0100 0600
3 0003 FF00 05FF
3 4000 4000 7FFF
3 0400 0400 7FFF
3 4000 8000 8000
3 0400 0800 8800
5 0000 1234 0010
5 8000 0000 0000
5 0001 0000 000F
5 0010 0000 000B
5 0100 0000 0007
5 1000 0000 0003
5 4000 0000 0001
6 0000 1234 1234
6 0400 1234 2469
6 007F A5C3 E1AD
6 FFFF 1234 EDCB
7 ACE1 0000 ACE1
7 ACE1 0001 59C3
7 ACE1 0008 E1E4
7 ACE1 000F E1E4
7 ACE1 00F3 670F

// ==== sources.f ====
source/alu_pkg.sv
source/alu_operand_if.sv
source/alu_sequencer.sv
source/alu_fixed_arith.sv
source/alu_bit_ops.sv
source/alu_result_stage.sv
source/alu_top.sv
tb/alu_chk.sv
tb/alu_tb.sv

// ==== Bender.yml ====
package:
  name: fixed_point_alu

sources:
  - target: any(simulation, synthesis)
    files:
      - source/alu_pkg.sv
      - source/alu_operand_if.sv
      - source/alu_sequencer.sv
      - source/alu_fixed_arith.sv
      - source/alu_bit_ops.sv
      - source/alu_result_stage.sv
      - source/alu_top.sv

  - target: test
    files:
      - tb/alu_chk.sv
      - tb/alu_tb.sv
